// File: include/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// data path and register width
`define XLEN 32

// register index width, 32 architectural registers
`define REG_ADDR_W 5

// word address width of the data memory, 64 words
`define DMEM_ADDR_W 6

`endif

// File: rtl/riscv_isa_pkg.sv
`default_nettype none

package riscv_isa_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLT    = 4'd5,
        // lui passes the immediate straight through
        ALU_PASS_B = 4'd6
    } alu_op_e;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_LW_SW   = 3'b010;

    // funct7 that turns add into sub
    localparam logic [6:0] F7_SUB     = 7'b0100000;

endpackage

`default_nettype wire

// File: rtl/pipe_pkg.sv
`default_nettype none

`include "core_defines.svh"

package pipe_pkg;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
        logic [31:0]            instr;
    } if_id_t;

    typedef struct packed {
        logic                   valid;
        riscv_isa_pkg::alu_op_e alu_op;
        logic [`REG_ADDR_W-1:0] rs1;
        logic                   rs1_re;
        logic [`REG_ADDR_W-1:0] rs2;
        logic                   rs2_re;
        logic [`XLEN-1:0]       rs1_val;
        logic [`XLEN-1:0]       rs2_val;
        logic [`XLEN-1:0]       imm;
        logic                   use_imm;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   rd_we;
        logic                   mem_re;
        logic                   mem_we;
    } id_ex_t;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       alu_val;
        logic [`XLEN-1:0]       store_val;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   rd_we;
        logic                   mem_re;
        logic                   mem_we;
    } ex_mem_t;

    // MEM/WB register, also the retire record
    typedef struct packed {
        logic                   valid;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       rd_val;
        logic                   rd_we;
    } wb_t;

endpackage

`default_nettype wire

// File: rtl/fetch_stage.sv
`default_nettype none
`timescale 1ns/100ps

`include "core_defines.svh"

module fetch_stage (
    input  wire                clk_i,
    input  wire                rst_n_i,
    input  wire                instr_valid_i,
    input  wire [31:0]         instr_i,
    output pipe_pkg::if_id_t   if_id_o
);

    logic [`XLEN-1:0] seq_pc;
    pipe_pkg::if_id_t fetch_q;

    // issue strobe is sampled here, then handed on to IF/ID
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            seq_pc  <= '0;
            fetch_q <= '0;
            if_id_o <= '0;
        end else begin
            fetch_q.valid <= instr_valid_i;
            fetch_q.pc    <= seq_pc;
            fetch_q.instr <= instr_i;
            if_id_o       <= fetch_q;
            // pc only moves on real instructions
            if (instr_valid_i) begin
                seq_pc <= seq_pc + `XLEN'd4;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/decode_stage.sv
`default_nettype none
`timescale 1ns/100ps

`include "core_defines.svh"

module decode_stage (
    input  wire                     clk_i,
    input  wire                     rst_n_i,
    input  wire pipe_pkg::if_id_t   if_id_i,
    input  wire pipe_pkg::wb_t      wb_i,
    output pipe_pkg::id_ex_t        id_ex_o
);

    riscv_isa_pkg::opcode_e opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    logic [`XLEN-1:0]       imm_i;
    logic [`XLEN-1:0]       imm_s;
    logic [`XLEN-1:0]       imm_u;
    logic [`XLEN-1:0]       regs [2**`REG_ADDR_W];
    pipe_pkg::id_ex_t       id_ex_d;

    assign opcode = riscv_isa_pkg::opcode_e'(if_id_i.instr[6:0]);
    assign funct3 = if_id_i.instr[14:12];
    assign funct7 = if_id_i.instr[31:25];

    assign imm_i = {{(`XLEN-12){if_id_i.instr[31]}}, if_id_i.instr[31:20]};
    assign imm_s = {{(`XLEN-12){if_id_i.instr[31]}}, if_id_i.instr[31:25], if_id_i.instr[11:7]};
    assign imm_u = {if_id_i.instr[31:12], 12'b0};

    // x0 reads zero, a same-cycle writeback wins over the array
    function automatic logic [`XLEN-1:0] rf_read(input logic [`REG_ADDR_W-1:0] addr);
        logic [`XLEN-1:0] val;
        if (addr == '0) begin
            val = '0;
        end else if (wb_i.valid && wb_i.rd_we && wb_i.rd == addr) begin
            val = wb_i.rd_val;
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    // shared by register and immediate forms
    function automatic riscv_isa_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic sub);
        riscv_isa_pkg::alu_op_e op;
        case (f3)
            riscv_isa_pkg::F3_ADD_SUB: op = sub ? riscv_isa_pkg::ALU_SUB : riscv_isa_pkg::ALU_ADD;
            riscv_isa_pkg::F3_SLT:     op = riscv_isa_pkg::ALU_SLT;
            riscv_isa_pkg::F3_XOR:     op = riscv_isa_pkg::ALU_XOR;
            riscv_isa_pkg::F3_OR:      op = riscv_isa_pkg::ALU_OR;
            riscv_isa_pkg::F3_AND:     op = riscv_isa_pkg::ALU_AND;
            default:                   op = riscv_isa_pkg::ALU_ADD;
        endcase
        return op;
    endfunction

    always_comb begin
        id_ex_d         = '0;
        id_ex_d.valid   = if_id_i.valid;
        id_ex_d.alu_op  = riscv_isa_pkg::ALU_ADD;
        id_ex_d.rs1     = if_id_i.instr[19:15];
        id_ex_d.rs2     = if_id_i.instr[24:20];
        id_ex_d.rd      = if_id_i.instr[11:7];
        id_ex_d.rs1_val = rf_read(if_id_i.instr[19:15]);
        id_ex_d.rs2_val = rf_read(if_id_i.instr[24:20]);
        case (opcode)
            riscv_isa_pkg::OPC_OP: begin
                id_ex_d.rs1_re = 1'b1;
                id_ex_d.rs2_re = 1'b1;
                id_ex_d.rd_we  = 1'b1;
                id_ex_d.alu_op = alu_sel(funct3, funct7 == riscv_isa_pkg::F7_SUB);
            end
            riscv_isa_pkg::OPC_OP_IMM: begin
                id_ex_d.rs1_re  = 1'b1;
                id_ex_d.rd_we   = 1'b1;
                id_ex_d.use_imm = 1'b1;
                id_ex_d.imm     = imm_i;
                id_ex_d.alu_op  = alu_sel(funct3, 1'b0);
            end
            riscv_isa_pkg::OPC_LUI: begin
                id_ex_d.rd_we   = 1'b1;
                id_ex_d.use_imm = 1'b1;
                id_ex_d.imm     = imm_u;
                id_ex_d.alu_op  = riscv_isa_pkg::ALU_PASS_B;
            end
            riscv_isa_pkg::OPC_LOAD: begin
                id_ex_d.rs1_re  = 1'b1;
                id_ex_d.rd_we   = 1'b1;
                id_ex_d.mem_re  = 1'b1;
                id_ex_d.use_imm = 1'b1;
                id_ex_d.imm     = imm_i;
            end
            riscv_isa_pkg::OPC_STORE: begin
                id_ex_d.rs1_re  = 1'b1;
                id_ex_d.rs2_re  = 1'b1;
                id_ex_d.mem_we  = 1'b1;
                id_ex_d.use_imm = 1'b1;
                id_ex_d.imm     = imm_s;
            end
            // unknown opcode still retires, with every enable low
            default: ;
        endcase
        if (id_ex_d.rd == '0) begin
            id_ex_d.rd_we = 1'b0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 2**`REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.valid && wb_i.rd_we) begin
            regs[wb_i.rd] <= wb_i.rd_val;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_ex_o <= '0;
        end else begin
            id_ex_o <= id_ex_d;
        end
    end

endmodule

`default_nettype wire

// File: rtl/execute_stage.sv
`default_nettype none
`timescale 1ns/100ps

`include "core_defines.svh"

module execute_stage (
    input  wire                      clk_i,
    input  wire                      rst_n_i,
    input  wire pipe_pkg::id_ex_t    id_ex_i,
    input  wire pipe_pkg::ex_mem_t   ex_mem_fwd_i,
    input  wire pipe_pkg::wb_t       wb_fwd_i,
    output pipe_pkg::ex_mem_t        ex_mem_o
);

    logic [`XLEN-1:0]  op_a;
    logic [`XLEN-1:0]  op_b;
    logic [`XLEN-1:0]  rs2_fwd;
    logic [`XLEN-1:0]  alu_res;
    logic              load_use;
    pipe_pkg::ex_mem_t ex_mem_d;

    // ex_mem first, then wb; a load in ex_mem has no data yet
    function automatic logic [`XLEN-1:0] fwd(
        input logic [`REG_ADDR_W-1:0] rs,
        input logic [`XLEN-1:0]       dec_val
    );
        logic [`XLEN-1:0] val;
        if (ex_mem_fwd_i.valid && ex_mem_fwd_i.rd_we && !ex_mem_fwd_i.mem_re &&
            ex_mem_fwd_i.rd == rs) begin
            val = ex_mem_fwd_i.alu_val;
        end else if (wb_fwd_i.valid && wb_fwd_i.rd_we && wb_fwd_i.rd == rs) begin
            val = wb_fwd_i.rd_val;
        end else begin
            val = dec_val;
        end
        return val;
    endfunction

    assign op_a    = fwd(id_ex_i.rs1, id_ex_i.rs1_val);
    assign rs2_fwd = fwd(id_ex_i.rs2, id_ex_i.rs2_val);
    assign op_b    = id_ex_i.use_imm ? id_ex_i.imm : rs2_fwd;

    always_comb begin
        case (id_ex_i.alu_op)
            riscv_isa_pkg::ALU_ADD:    alu_res = op_a + op_b;
            riscv_isa_pkg::ALU_SUB:    alu_res = op_a - op_b;
            riscv_isa_pkg::ALU_AND:    alu_res = op_a & op_b;
            riscv_isa_pkg::ALU_OR:     alu_res = op_a | op_b;
            riscv_isa_pkg::ALU_XOR:    alu_res = op_a ^ op_b;
            riscv_isa_pkg::ALU_SLT:    alu_res = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            riscv_isa_pkg::ALU_PASS_B: alu_res = op_b;
            default:                   alu_res = '0;
        endcase
    end

    always_comb begin
        ex_mem_d.valid     = id_ex_i.valid;
        ex_mem_d.alu_val   = alu_res;
        ex_mem_d.store_val = rs2_fwd;
        ex_mem_d.rd        = id_ex_i.rd;
        ex_mem_d.rd_we     = id_ex_i.rd_we;
        ex_mem_d.mem_re    = id_ex_i.mem_re;
        ex_mem_d.mem_we    = id_ex_i.mem_we;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_mem_o <= '0;
        end else begin
            ex_mem_o <= ex_mem_d;
        end
    end

    // issuer must leave a slot after a load feeding the next instruction
    assign load_use = ex_mem_fwd_i.valid && ex_mem_fwd_i.mem_re && ex_mem_fwd_i.rd_we &&
                      ((id_ex_i.rs1_re && id_ex_i.rs1 == ex_mem_fwd_i.rd) ||
                       (id_ex_i.rs2_re && id_ex_i.rs2 == ex_mem_fwd_i.rd));

    a_no_load_use: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) id_ex_i.valid |-> !load_use
    ) else $error("load-use hazard on x%0d", ex_mem_fwd_i.rd);

endmodule

`default_nettype wire

// File: rtl/mem_wb_stage.sv
`default_nettype none
`timescale 1ns/100ps

`include "core_defines.svh"

module mem_wb_stage (
    input  wire                      clk_i,
    input  wire                      rst_n_i,
    input  wire pipe_pkg::ex_mem_t   ex_mem_i,
    output pipe_pkg::wb_t            wb_o
);

    logic [`XLEN-1:0]        dmem [2**`DMEM_ADDR_W];
    logic [`DMEM_ADDR_W-1:0] word_addr;
    pipe_pkg::wb_t           wb_d;

    // word access only, byte offset ignored
    assign word_addr = ex_mem_i.alu_val[`DMEM_ADDR_W+1:2];

    always_ff @(posedge clk_i) begin
        if (ex_mem_i.valid && ex_mem_i.mem_we) begin
            dmem[word_addr] <= ex_mem_i.store_val;
        end
    end

    always_comb begin
        wb_d.valid  = ex_mem_i.valid;
        wb_d.rd     = ex_mem_i.rd;
        wb_d.rd_we  = ex_mem_i.rd_we;
        // load data comes back in the same cycle
        wb_d.rd_val = ex_mem_i.mem_re ? dmem[word_addr] : ex_mem_i.alu_val;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_o <= '0;
        end else begin
            wb_o <= wb_d;
        end
    end

    a_mem_excl: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        ex_mem_i.valid |-> !(ex_mem_i.mem_re && ex_mem_i.mem_we)
    ) else $error("load and store set together");

endmodule

`default_nettype wire

// File: rtl/core_top.sv
`default_nettype none
`timescale 1ns/100ps

module core_top (
    input  wire              clk_i,
    input  wire              rst_n_i,
    input  wire              instr_valid_i,
    input  wire [31:0]       instr_i,
    output pipe_pkg::wb_t    retire_o
);

    pipe_pkg::if_id_t  if_id;
    pipe_pkg::id_ex_t  id_ex;
    pipe_pkg::ex_mem_t ex_mem;
    pipe_pkg::wb_t     wb;

    fetch_stage fetch_stage_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .if_id_o       (if_id)
    );

    // wb also feeds the register file write port
    decode_stage decode_stage_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .if_id_i (if_id),
        .wb_i    (wb),
        .id_ex_o (id_ex)
    );

    execute_stage execute_stage_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .id_ex_i      (id_ex),
        .ex_mem_fwd_i (ex_mem),
        .wb_fwd_i     (wb),
        .ex_mem_o     (ex_mem)
    );

    mem_wb_stage mem_wb_stage_i (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .ex_mem_i (ex_mem),
        .wb_o     (wb)
    );

    assign retire_o = wb;

endmodule

`default_nettype wire

// File: verif/core_tb.sv
`default_nettype none
`timescale 1ns/100ps

`include "core_defines.svh"

module core_tb;

    localparam int RST_CYCLES  = 3;
    localparam int LATENCY     = 4;
    localparam int N_STREAMS   = 4;
    localparam int ALU_SLOTS   = 120;
    localparam int FWD_SLOTS   = 120;
    localparam int MEM_SLOTS   = 100;
    localparam int MISC_SLOTS  = 60;
    localparam int TOTAL_SLOTS = ALU_SLOTS + FWD_SLOTS + MEM_SLOTS + MISC_SLOTS;
    // reset, idle window, every slot, one drain per stream, final idle, then margin
    localparam int CYCLE_LIMIT = RST_CYCLES + LATENCY + TOTAL_SLOTS +
                                 N_STREAMS * (LATENCY + 2) + LATENCY + 1 + 50;
    localparam int MEM_WORDS   = 2**`DMEM_ADDR_W;
    localparam int MODE_ALU    = 0;
    localparam int MODE_FWD    = 1;
    localparam int MODE_MEM    = 2;
    localparam int MODE_MISC   = 3;
    // custom-0 space, not decoded by the core
    localparam logic [6:0] UNKNOWN_OPC = 7'b0001011;

    logic                   clk_i;
    logic                   rst_n_i;
    logic                   instr_valid_i;
    logic [31:0]            instr_i;
    pipe_pkg::wb_t          retire_o;

    logic [`XLEN-1:0]       mregs [2**`REG_ADDR_W];
    logic [`XLEN-1:0]       mmem [MEM_WORDS];
    bit                     written [MEM_WORDS];
    pipe_pkg::wb_t          exp_q [$];
    int                     due_q [$];
    int                     cycle_cnt;
    int                     issued;
    int                     retired;
    int                     test_errs;
    int                     test_checks;
    int                     tests_passed;
    int                     tests_failed;
    string                  cur_test;
    bit                     last_load;
    logic [`REG_ADDR_W-1:0] last_load_rd;

    core_top core_top_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .retire_o      (retire_o)
    );

    always #10 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: core stopped retiring after %0d cycles, %0d still outstanding",
                     cycle_cnt, exp_q.size());
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic compare_wb(input string name, input pipe_pkg::wb_t exp,
                              input pipe_pkg::wb_t act);
        test_checks++;
        // rd and rd_val only mean something when a register is written
        if (act.valid !== exp.valid || act.rd_we !== exp.rd_we ||
            (exp.rd_we && (act.rd !== exp.rd || act.rd_val !== exp.rd_val))) begin
            test_errs++;
            $display("MISMATCH %s retire: expected we=%b rd=x%0d val=%h, actual we=%b rd=x%0d val=%h",
                     name, exp.rd_we, exp.rd, exp.rd_val, act.rd_we, act.rd, act.rd_val);
        end
    endtask

    task automatic compare_valid(input string name, input logic exp, input logic act);
        test_checks++;
        if (act !== exp) begin
            test_errs++;
            $display("MISMATCH %s retire valid: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic compare_cycle(input string name, input int exp, input int act);
        test_checks++;
        if (act != exp) begin
            test_errs++;
            $display("MISMATCH %s retire cycle: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic compare_count(input string name, input int exp, input int act);
        test_checks++;
        if (act != exp) begin
            test_errs++;
            $display("MISMATCH %s count: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    function automatic logic [`XLEN-1:0] alu_ref(input logic [2:0] f3, input logic sub,
                                                  input logic [`XLEN-1:0] a,
                                                  input logic [`XLEN-1:0] b);
        logic [`XLEN-1:0] r;
        case (f3)
            riscv_isa_pkg::F3_ADD_SUB: r = sub ? a - b : a + b;
            riscv_isa_pkg::F3_SLT:     r = ($signed(a) < $signed(b)) ? `XLEN'd1 : `XLEN'd0;
            riscv_isa_pkg::F3_XOR:     r = a ^ b;
            riscv_isa_pkg::F3_OR:      r = a | b;
            riscv_isa_pkg::F3_AND:     r = a & b;
            default:                   r = '0;
        endcase
        return r;
    endfunction

    // executes one word in program order and returns its retire record
    function automatic pipe_pkg::wb_t exec_model(input logic [31:0] instr);
        pipe_pkg::wb_t    res;
        logic [6:0]       opc;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] imm_i;
        logic [`XLEN-1:0] imm_s;
        logic [`XLEN-1:0] addr;
        opc       = instr[6:0];
        a         = mregs[instr[19:15]];
        b         = mregs[instr[24:20]];
        imm_i     = {{(`XLEN-12){instr[31]}}, instr[31:20]};
        imm_s     = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
        res       = '0;
        res.valid = 1'b1;
        res.rd    = instr[11:7];
        case (opc)
            riscv_isa_pkg::OPC_OP: begin
                res.rd_we  = 1'b1;
                res.rd_val = alu_ref(instr[14:12], instr[31:25] == riscv_isa_pkg::F7_SUB, a, b);
            end
            riscv_isa_pkg::OPC_OP_IMM: begin
                res.rd_we  = 1'b1;
                res.rd_val = alu_ref(instr[14:12], 1'b0, a, imm_i);
            end
            riscv_isa_pkg::OPC_LUI: begin
                res.rd_we  = 1'b1;
                res.rd_val = {instr[31:12], 12'b0};
            end
            riscv_isa_pkg::OPC_LOAD: begin
                addr       = a + imm_i;
                res.rd_we  = 1'b1;
                res.rd_val = mmem[addr[`DMEM_ADDR_W+1:2]];
            end
            riscv_isa_pkg::OPC_STORE: begin
                addr = a + imm_s;
                mmem[addr[`DMEM_ADDR_W+1:2]]    = b;
                written[addr[`DMEM_ADDR_W+1:2]] = 1'b1;
            end
            default: ;
        endcase
        if (res.rd == '0) begin
            res.rd_we = 1'b0;
        end
        if (res.rd_we) begin
            mregs[res.rd] = res.rd_val;
        end
        return res;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, riscv_isa_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, riscv_isa_pkg::F3_LW_SW, imm[4:0], riscv_isa_pkg::OPC_STORE};
    endfunction

    function automatic logic [4:0] rnd_reg(input int span);
        return 5'($urandom % span);
    endfunction

    // small spans pack dependencies close together
    function automatic logic [31:0] gen_alu(input int span, input bit rd_zero);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        int          op;
        int          pick;
        logic [31:0] res;
        rd   = rd_zero ? 5'd0 : rnd_reg(span);
        rs1  = rnd_reg(span);
        rs2  = rnd_reg(span);
        op   = int'($urandom % 6);
        pick = int'($urandom % 10);
        f7   = 7'b0;
        case (op)
            0: f3 = riscv_isa_pkg::F3_ADD_SUB;
            1: begin
                f3 = riscv_isa_pkg::F3_ADD_SUB;
                f7 = riscv_isa_pkg::F7_SUB;
            end
            2: f3 = riscv_isa_pkg::F3_AND;
            3: f3 = riscv_isa_pkg::F3_OR;
            4: f3 = riscv_isa_pkg::F3_XOR;
            default: f3 = riscv_isa_pkg::F3_SLT;
        endcase
        if (pick < 5) begin
            res = enc_r(f7, rs2, rs1, f3, rd);
        end else if (pick < 9) begin
            res = enc_i(12'($urandom), rs1, f3, rd, riscv_isa_pkg::OPC_OP_IMM);
        end else begin
            res = {20'($urandom), rd, riscv_isa_pkg::OPC_LUI};
        end
        return res;
    endfunction

    // target word stays in range; x0 base when the offset does not fit
    function automatic logic [31:0] gen_mem(input bit want_load);
        int          word;
        int          diff;
        logic [4:0]  base;
        logic [4:0]  other;
        logic [31:0] res;
        word  = int'($urandom % MEM_WORDS);
        base  = rnd_reg(8);
        other = rnd_reg(8);
        diff  = word * 4 - int'(mregs[base]);
        if (diff < -2048 || diff > 2047) begin
            base = 5'd0;
            diff = word * 4;
        end
        if (want_load && written[word]) begin
            res = enc_i(12'(diff), base, riscv_isa_pkg::F3_LW_SW, other, riscv_isa_pkg::OPC_LOAD);
        end else begin
            res = enc_s(12'(diff), other, base);
        end
        return res;
    endfunction

    function automatic logic [31:0] gen_instr(input int mode);
        int          pick;
        logic [31:0] res;
        pick = int'($urandom % 10);
        case (mode)
            MODE_ALU: res = gen_alu(32, 1'b0);
            MODE_FWD: res = gen_alu(4, 1'b0);
            MODE_MEM: begin
                if (pick < 4) res = gen_mem(1'b0);
                else if (pick < 7) res = gen_mem(1'b1);
                else res = gen_alu(8, 1'b0);
            end
            default: begin
                if (pick < 3) res = {25'($urandom), UNKNOWN_OPC};
                else if (pick < 6) res = gen_alu(32, 1'b1);
                else res = gen_alu(4, 1'b0);
            end
        endcase
        return res;
    endfunction

    function automatic bit load_hazard(input logic [31:0] instr);
        logic [6:0] opc;
        bit         reads1;
        bit         reads2;
        opc    = instr[6:0];
        reads1 = opc == riscv_isa_pkg::OPC_OP || opc == riscv_isa_pkg::OPC_OP_IMM ||
                 opc == riscv_isa_pkg::OPC_LOAD || opc == riscv_isa_pkg::OPC_STORE;
        reads2 = opc == riscv_isa_pkg::OPC_OP || opc == riscv_isa_pkg::OPC_STORE;
        return last_load && ((reads1 && instr[19:15] == last_load_rd) ||
                             (reads2 && instr[24:20] == last_load_rd));
    endfunction

    task automatic issue(input logic [31:0] instr);
        instr_valid_i = 1'b1;
        instr_i       = instr;
        exp_q.push_back(exec_model(instr));
        // sampled on the next rising edge, retired LATENCY edges later
        due_q.push_back(cycle_cnt + 1 + LATENCY);
        issued++;
        last_load    = instr[6:0] == riscv_isa_pkg::OPC_LOAD && instr[11:7] != 5'd0;
        last_load_rd = instr[11:7];
    endtask

    task automatic bubble();
        instr_valid_i = 1'b0;
        instr_i       = $urandom;
        last_load     = 1'b0;
    endtask

    task automatic drain();
        do begin
            @(negedge clk_i);
            bubble();
        end while (exp_q.size() != 0);
    endtask

    task automatic finish_test(input string name);
        if (test_errs == 0) begin
            tests_passed++;
            $display("test %s: ok, %0d checks", name, test_checks);
        end else begin
            tests_failed++;
            $display("test %s: failed, %0d of %0d checks wrong", name, test_errs, test_checks);
        end
        test_errs   = 0;
        test_checks = 0;
    endtask

    task automatic run_test(input string name, input int mode, input int slots);
        logic [31:0] pending;
        bit          has_pending;
        cur_test    = name;
        has_pending = 1'b0;
        for (int s = 0; s < slots; s++) begin
            @(negedge clk_i);
            if (!has_pending && $urandom % 20 == 0) begin
                bubble();
            end else begin
                if (!has_pending) begin
                    pending     = gen_instr(mode);
                    has_pending = 1'b1;
                end
                // load result not yet forwardable, hold the consumer one slot
                if (load_hazard(pending)) begin
                    bubble();
                end else begin
                    issue(pending);
                    has_pending = 1'b0;
                end
            end
        end
        drain();
        finish_test(name);
    endtask

    always @(negedge clk_i) begin
        pipe_pkg::wb_t want;
        if (rst_n_i && retire_o.valid) begin
            retired++;
            if (exp_q.size() == 0) begin
                test_errs++;
                $display("%s: core retired an instruction that was never issued", cur_test);
            end else begin
                want = exp_q.pop_front();
                compare_wb(cur_test, want, retire_o);
                compare_cycle(cur_test, due_q.pop_front(), cycle_cnt);
            end
        end
    end

    initial begin
        void'($urandom(18711));
        clk_i         = 1'b0;
        rst_n_i       = 1'b0;
        // words offered while in reset must never retire
        instr_valid_i = 1'b1;
        instr_i       = $urandom;
        cycle_cnt     = 0;
        issued        = 0;
        retired       = 0;
        test_errs     = 0;
        test_checks   = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        last_load     = 1'b0;
        last_load_rd  = '0;
        for (int i = 0; i < 2**`REG_ADDR_W; i++) begin
            mregs[i] = '0;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            written[i] = 1'b0;
        end

        cur_test = "reset";
        repeat (RST_CYCLES) begin
            @(negedge clk_i);
            compare_valid(cur_test, 1'b0, retire_o.valid);
        end
        rst_n_i = 1'b1;
        bubble();
        repeat (LATENCY) begin
            @(negedge clk_i);
            compare_valid(cur_test, 1'b0, retire_o.valid);
        end
        finish_test(cur_test);

        run_test("alu", MODE_ALU, ALU_SLOTS);
        run_test("forwarding", MODE_FWD, FWD_SLOTS);
        run_test("memory", MODE_MEM, MEM_SLOTS);
        run_test("x0_unknown", MODE_MISC, MISC_SLOTS);

        // idle window so that a late extra retire is still counted
        cur_test = "completeness";
        repeat (LATENCY + 1) begin
            @(negedge clk_i);
        end
        compare_count(cur_test, issued, retired);
        finish_test(cur_test);

        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+include
rtl/riscv_isa_pkg.sv
rtl/pipe_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/mem_wb_stage.sv
rtl/core_top.sv
verif/core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= core_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
FILELIST  ?= list.f

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard include/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf $(OBJ_DIR)
